//--- rtl/screenPkg.sv
package screenPkg;

   // Tile edge in pixels
   localparam int TileSize = 32;

   // Visible grid, in tiles
   localparam int GridCols = 25;
   localparam int GridRows = 17;

   // Signed pixel coordinate width
   localparam int CoordWidth = 11;

   // Sub-pixel bits carried by the movers
   localparam int FracWidth = 4;

   // Maze address is row * GridCols + column
   localparam int TileAddrWidth = 10;

   // Maze tile value, nonzero means wall
   localparam int TileWidth = 4;

endpackage

//--- rtl/gamePkg.sv
package gamePkg;

   // Mover FSM
   //   Waiting  : at rest on a tile, keys are sampled on eof
   //   Querying : wall lookup in flight at the maze port
   //   Moving   : stepping toward the target tile once per frame
   typedef enum logic [1:0]
   {
      Waiting,
      Querying,
      Moving
   } MoverState;

   // Direction of the current or last move
   typedef enum logic [1:0]
   {
      DirUp,
      DirDown,
      DirLeft,
      DirRight
   } MoveDir;

   // Sprite numbers as laid out in the sprite ROM
   typedef enum logic [2:0]
   {
      Face   = 3'd0,
      Up1,
      Up2,
      Right1,
      Right2,
      Left1,
      Left2  = 3'd6
   } SpriteId;

endpackage

//--- rtl/playerMover.sv
module playerMover
#(
   parameter int Speed  = 16,
   parameter int StartX = 128,
   parameter int StartY = 128
)
(
   input  logic                                     clk,
   input  logic                                     reset_n,
   input  logic                                     eof,
   input  logic                                     keyUp,
   input  logic                                     keyDown,
   input  logic                                     keyLeft,
   input  logic                                     keyRight,
   input  logic                                     replyValid,
   input  logic [screenPkg::TileWidth-1:0]          replyData,
   output logic signed [screenPkg::CoordWidth-1:0]  posX,
   output logic signed [screenPkg::CoordWidth-1:0]  posY,
   output gamePkg::SpriteId                         sprite,
   output logic                                     queryValid,
   output logic [screenPkg::TileAddrWidth-1:0]      queryAddr
);

   // Fixed-point position width, integer pixels plus fraction
   localparam int FixWidth = screenPkg::CoordWidth + screenPkg::FracWidth;
   // Pixel to tile index shift
   localparam int TileShift = $clog2(screenPkg::TileSize);
   // Signed tile index, one spare bit for the -1 neighbour
   localparam int TileIdxWidth = screenPkg::CoordWidth - TileShift + 1;

   // Speed counts whole pixels per frame, scaled into sixteenths here
   localparam logic signed [FixWidth-1:0] StepFix = FixWidth'(Speed * (2 ** screenPkg::FracWidth));

   // Neighbour offsets in tiles
   localparam logic signed [TileIdxWidth-1:0] StepBack = -1;
   localparam logic signed [TileIdxWidth-1:0] StepFwd  = 1;
   localparam logic signed [TileIdxWidth-1:0] NoStep   = 0;

   gamePkg::MoverState                        state;
   gamePkg::MoveDir                           dir;
   gamePkg::MoveDir                           keyDir;
   gamePkg::SpriteId                          movingSprite;

   // Position with hidden fraction
   logic signed [FixWidth-1:0]                posFixX;
   logic signed [FixWidth-1:0]                posFixY;

   // Target tile origin in pixels, and the same in fixed point
   logic signed [screenPkg::CoordWidth-1:0]   targetX;
   logic signed [screenPkg::CoordWidth-1:0]   targetY;
   logic signed [FixWidth-1:0]                targetFixX;
   logic signed [FixWidth-1:0]                targetFixY;

   // Tile indices of the current and the target tile
   logic signed [TileIdxWidth-1:0]            curCol;
   logic signed [TileIdxWidth-1:0]            curRow;
   logic signed [TileIdxWidth-1:0]            dCol;
   logic signed [TileIdxWidth-1:0]            dRow;
   logic signed [TileIdxWidth-1:0]            tgtCol;
   logic signed [TileIdxWidth-1:0]            tgtRow;

   logic                                      keyHit;
   logic                                      inGrid;
   logic                                      startQuery;
   logic                                      credit;
   logic                                      phase;

   // Step along the axis of motion
   logic                                      stepNeg;
   logic                                      stepVert;
   logic signed [FixWidth-1:0]                axisPos;
   logic signed [FixWidth-1:0]                axisTarget;
   logic signed [FixWidth-1:0]                axisNext;
   logic                                      arrive;

   assign posX = posFixX[FixWidth-1:screenPkg::FracWidth];
   assign posY = posFixY[FixWidth-1:screenPkg::FracWidth];

   assign targetFixX = {targetX, {screenPkg::FracWidth{1'b0}}};
   assign targetFixY = {targetY, {screenPkg::FracWidth{1'b0}}};

   // At rest the position is tile aligned, so a shift gives the tile
   assign curCol = TileIdxWidth'(posX >>> TileShift);
   assign curRow = TileIdxWidth'(posY >>> TileShift);

   // Key priority is up, down, right, left
   always_comb
   begin
      keyHit = 1'b1;
      keyDir = gamePkg::DirUp;
      dCol   = NoStep;
      dRow   = NoStep;
      if (keyUp)
      begin
         dRow = StepBack;
      end
      else if (keyDown)
      begin
         keyDir = gamePkg::DirDown;
         dRow   = StepFwd;
      end
      else if (keyRight)
      begin
         keyDir = gamePkg::DirRight;
         dCol   = StepFwd;
      end
      else if (keyLeft)
      begin
         keyDir = gamePkg::DirLeft;
         dCol   = StepBack;
      end
      else
      begin
         keyHit = 1'b0;
      end
   end

   assign tgtCol = curCol + dCol;
   assign tgtRow = curRow + dRow;

   // Off-grid targets are refused like walls, no lookup needed
   assign inGrid = (tgtCol >= 0) && (tgtCol < screenPkg::GridCols) &&
                   (tgtRow >= 0) && (tgtRow < screenPkg::GridRows);

   // One query per credit
   assign startQuery = (state == gamePkg::Waiting) && eof && keyHit && inGrid && credit;

   // Next fixed-point value on the moving axis and arrival test
   always_comb
   begin
      stepNeg    = (dir == gamePkg::DirUp) || (dir == gamePkg::DirLeft);
      stepVert   = (dir == gamePkg::DirUp) || (dir == gamePkg::DirDown);
      axisPos    = stepVert ? posFixY : posFixX;
      axisTarget = stepVert ? targetFixY : targetFixX;
      axisNext   = stepNeg ? axisPos - StepFix : axisPos + StepFix;
      // Reaching or passing the target counts as arrival
      arrive     = stepNeg ? (axisNext <= axisTarget) : (axisNext >= axisTarget);
   end

   // Walking image from direction and phase, down has no walk cycle
   always_comb
   begin
      case (dir)
         gamePkg::DirUp:    movingSprite = phase ? gamePkg::Up2 : gamePkg::Up1;
         gamePkg::DirRight: movingSprite = phase ? gamePkg::Right2 : gamePkg::Right1;
         gamePkg::DirLeft:  movingSprite = phase ? gamePkg::Left2 : gamePkg::Left1;
         default:           movingSprite = gamePkg::Face;
      endcase
   end

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         state      <= gamePkg::Waiting;
         dir        <= gamePkg::DirUp;
         posFixX    <= {screenPkg::CoordWidth'(StartX), {screenPkg::FracWidth{1'b0}}};
         posFixY    <= {screenPkg::CoordWidth'(StartY), {screenPkg::FracWidth{1'b0}}};
         credit     <= 1'b1;
         queryValid <= 1'b0;
         phase      <= 1'b0;
         sprite     <= gamePkg::Face;
      end
      else
      begin
         // Query is a single-cycle pulse
         queryValid <= 1'b0;

         // Reply refunds the credit
         if (replyValid)
         begin
            credit <= 1'b1;
         end

         case (state)
            gamePkg::Waiting:
            begin
               if (startQuery)
               begin
                  dir        <= keyDir;
                  queryValid <= 1'b1;
                  credit     <= 1'b0;
                  state      <= gamePkg::Querying;
               end
            end

            // eof is ignored until the tile value is back
            gamePkg::Querying:
            begin
               if (replyValid)
               begin
                  if (replyData == '0)
                  begin
                     state <= gamePkg::Moving;
                     // Walk cycle restarts on the first image
                     phase <= 1'b0;
                  end
                  else
                  begin
                     state <= gamePkg::Waiting;
                  end
               end
            end

            gamePkg::Moving:
            begin
               if (eof)
               begin
                  if (arrive)
                  begin
                     // Snap exactly onto the tile, fraction cleared
                     posFixX <= targetFixX;
                     posFixY <= targetFixY;
                     state   <= gamePkg::Waiting;
                  end
                  else if (stepVert)
                  begin
                     posFixY <= axisNext;
                  end
                  else
                  begin
                     posFixX <= axisNext;
                  end
               end
            end

            default:
            begin
               state <= gamePkg::Waiting;
            end
         endcase

         // Sprite follows the frame rate
         if (eof)
         begin
            if (state == gamePkg::Moving)
            begin
               sprite <= movingSprite;
               phase  <= ~phase;
            end
            else
            begin
               sprite <= gamePkg::Face;
            end
         end
      end
   end

   // Target and maze address captured with the query
   always_ff @(posedge clk)
   begin
      if (startQuery)
      begin
         targetX   <= screenPkg::CoordWidth'(tgtCol * screenPkg::TileSize);
         targetY   <= screenPkg::CoordWidth'(tgtRow * screenPkg::TileSize);
         queryAddr <= screenPkg::TileAddrWidth'(tgtRow * screenPkg::GridCols + tgtCol);
      end
   end

endmodule

//--- rtl/mazePort.sv
module mazePort
(
   input  logic                                 clk,
   input  logic                                 reset_n,
   input  logic                                 query1Valid,
   input  logic [screenPkg::TileAddrWidth-1:0]  query1Addr,
   input  logic                                 query2Valid,
   input  logic [screenPkg::TileAddrWidth-1:0]  query2Addr,
   output logic                                 reply1Valid,
   output logic                                 reply2Valid,
   output logic [screenPkg::TileWidth-1:0]      replyData,
   output logic [screenPkg::TileAddrWidth-1:0]  ramRaddr,
   input  logic [screenPkg::TileWidth-1:0]      ramRdata
);

   // One pending query per requester, never more thanks to the credit
   logic                                        pend1;
   logic                                        pend2;
   logic [screenPkg::TileAddrWidth-1:0]         addr1;
   logic [screenPkg::TileAddrWidth-1:0]         addr2;

   // Round-robin pointer, set means player 2 was served last
   logic                                        lastGrant2;

   logic                                        grant1;
   logic                                        grant2;

   // Return pipeline, one stage to match the RAM latency
   logic                                        retValid;
   logic                                        retOwner2;

   // Player 1 wins a tie unless it was served last
   assign grant1 = pend1 && (!pend2 || lastGrant2);
   assign grant2 = pend2 && !grant1;

   // Granted address goes straight to the RAM this cycle
   assign ramRaddr = grant2 ? addr2 : addr1;

   // Shared data bus, qualified per requester
   assign replyData   = ramRdata;
   assign reply1Valid = retValid && !retOwner2;
   assign reply2Valid = retValid && retOwner2;

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         pend1      <= 1'b0;
         pend2      <= 1'b0;
         addr1      <= '0;
         addr2      <= '0;
         lastGrant2 <= 1'b1;
         retValid   <= 1'b0;
         retOwner2  <= 1'b0;
      end
      else
      begin
         // Grant clears the pending flag
         if (grant1)
         begin
            pend1 <= 1'b0;
         end
         if (grant2)
         begin
            pend2 <= 1'b0;
         end

         // A new query cannot meet its own grant, the credit forbids it
         if (query1Valid)
         begin
            pend1 <= 1'b1;
            addr1 <= query1Addr;
         end
         if (query2Valid)
         begin
            pend2 <= 1'b1;
            addr2 <= query2Addr;
         end

         // Pointer moves only when someone is served
         if (grant1)
         begin
            lastGrant2 <= 1'b0;
         end
         else if (grant2)
         begin
            lastGrant2 <= 1'b1;
         end

         // Remember who owns the read now in flight
         retValid  <= grant1 || grant2;
         retOwner2 <= grant2;
      end
   end

endmodule

//--- rtl/gameController.sv
module gameController
#(
   parameter int Speed1  = 16,
   parameter int Speed2  = 3,
   parameter int Start1X = 128,
   parameter int Start1Y = 128,
   parameter int Start2X = 448,
   parameter int Start2Y = 448
)
(
   input  logic                                     clk,
   input  logic                                     reset_n,
   // One pulse per frame
   input  logic                                     eof,
   // Joystick of player 1
   input  logic                                     p1Up,
   input  logic                                     p1Down,
   input  logic                                     p1Left,
   input  logic                                     p1Right,
   // Joystick of player 2
   input  logic                                     p2Up,
   input  logic                                     p2Down,
   input  logic                                     p2Left,
   input  logic                                     p2Right,
   // Player pixel positions
   output logic signed [screenPkg::CoordWidth-1:0]  player1X,
   output logic signed [screenPkg::CoordWidth-1:0]  player1Y,
   output logic signed [screenPkg::CoordWidth-1:0]  player2X,
   output logic signed [screenPkg::CoordWidth-1:0]  player2Y,
   output gamePkg::SpriteId                         player1Sprite,
   output gamePkg::SpriteId                         player2Sprite,
   // Maze RAM read port, data one cycle after address
   output logic [screenPkg::TileAddrWidth-1:0]      ramRaddr,
   input  logic [screenPkg::TileWidth-1:0]          ramRdata
);

   // Mover to maze port lookups
   logic                                            query1Valid;
   logic [screenPkg::TileAddrWidth-1:0]             query1Addr;
   logic                                            query2Valid;
   logic [screenPkg::TileAddrWidth-1:0]             query2Addr;
   logic                                            reply1Valid;
   logic                                            reply2Valid;
   logic [screenPkg::TileWidth-1:0]                 replyData;

   playerMover #(
      .Speed  (Speed1),
      .StartX (Start1X),
      .StartY (Start1Y)
   ) mover1 (
      .clk        (clk),
      .reset_n    (reset_n),
      .eof        (eof),
      .keyUp      (p1Up),
      .keyDown    (p1Down),
      .keyLeft    (p1Left),
      .keyRight   (p1Right),
      .replyValid (reply1Valid),
      .replyData  (replyData),
      .posX       (player1X),
      .posY       (player1Y),
      .sprite     (player1Sprite),
      .queryValid (query1Valid),
      .queryAddr  (query1Addr)
   );

   playerMover #(
      .Speed  (Speed2),
      .StartX (Start2X),
      .StartY (Start2Y)
   ) mover2 (
      .clk        (clk),
      .reset_n    (reset_n),
      .eof        (eof),
      .keyUp      (p2Up),
      .keyDown    (p2Down),
      .keyLeft    (p2Left),
      .keyRight   (p2Right),
      .replyValid (reply2Valid),
      .replyData  (replyData),
      .posX       (player2X),
      .posY       (player2Y),
      .sprite     (player2Sprite),
      .queryValid (query2Valid),
      .queryAddr  (query2Addr)
   );

   // Both wall lookups share the single RAM read port
   mazePort port (
      .clk         (clk),
      .reset_n     (reset_n),
      .query1Valid (query1Valid),
      .query1Addr  (query1Addr),
      .query2Valid (query2Valid),
      .query2Addr  (query2Addr),
      .reply1Valid (reply1Valid),
      .reply2Valid (reply2Valid),
      .replyData   (replyData),
      .ramRaddr    (ramRaddr),
      .ramRdata    (ramRdata)
   );

endmodule

//--- tests/gameController_assertions.sv
module mazePortAssertions
(
   input logic                                 clk,
   input logic                                 reset_n,
   input logic                                 query1Valid,
   input logic                                 query2Valid,
   input logic                                 grant1,
   input logic                                 grant2,
   input logic                                 reply1Valid,
   input logic                                 reply2Valid,
   input logic [screenPkg::TileAddrWidth-1:0]  ramRaddr
);

   localparam int NumTiles = screenPkg::GridCols * screenPkg::GridRows;

   // RAM read only for a query raised one or two cycles before
   assert property (@(posedge clk) disable iff (!reset_n)
                    grant1 |-> ($past(query1Valid) || $past(query1Valid, 2)))
      else $error("Player 1 RAM read granted with no pending query");

   assert property (@(posedge clk) disable iff (!reset_n)
                    grant2 |-> ($past(query2Valid) || $past(query2Valid, 2)))
      else $error("Player 2 RAM read granted with no pending query");

   // Each query answered two or three cycles later, depending on arbitration
   assert property (@(posedge clk) disable iff (!reset_n)
                    $past(query1Valid, 3) |-> (reply1Valid || $past(reply1Valid)))
      else $error("Player 1 query not answered within three cycles");

   assert property (@(posedge clk) disable iff (!reset_n)
                    $past(query2Valid, 3) |-> (reply2Valid || $past(reply2Valid)))
      else $error("Player 2 query not answered within three cycles");

   // And no reply without such a query
   assert property (@(posedge clk) disable iff (!reset_n)
                    reply1Valid |-> ($past(query1Valid, 2) || $past(query1Valid, 3)))
      else $error("Player 1 reply without a query two or three cycles earlier");

   assert property (@(posedge clk) disable iff (!reset_n)
                    reply2Valid |-> ($past(query2Valid, 2) || $past(query2Valid, 3)))
      else $error("Player 2 reply without a query two or three cycles earlier");

   // Queries in the same cycle come back one per cycle, never together
   assert property (@(posedge clk) disable iff (!reset_n)
                    $past(query1Valid && query2Valid, 3) |->
                    ((reply1Valid != reply2Valid) &&
                     (reply1Valid == $past(reply2Valid)) &&
                     (reply2Valid == $past(reply1Valid))))
      else $error("Replies to queries of the same cycle not returned one per cycle");

   // Address stays inside the maze
   assert property (@(posedge clk) disable iff (!reset_n)
                    (grant1 || grant2) |-> (ramRaddr < NumTiles))
      else $error("RAM address outside the maze");

endmodule

bind mazePort mazePortAssertions portChecks
(
   .clk         (clk),
   .reset_n     (reset_n),
   .query1Valid (query1Valid),
   .query2Valid (query2Valid),
   .grant1      (grant1),
   .grant2      (grant2),
   .reply1Valid (reply1Valid),
   .reply2Valid (reply2Valid),
   .ramRaddr    (ramRaddr)
);

//--- tests/tb_gameController.sv
module tb_gameController;

   localparam int ClockPeriod = 20;
   localparam int DriveDelay  = 2;
   localparam int ResetCycles = 10;
   // Cycles from one eof pulse to the next
   localparam int FramePeriod = 24;
   localparam int CheckDelay  = 12;
   localparam int NumFrames   = 400;
   localparam int NumTiles    = screenPkg::GridCols * screenPkg::GridRows;
   localparam int FixScale    = 16;
   localparam int TimeoutTime = (NumFrames * FramePeriod + ResetCycles + 200) * ClockPeriod;

   // Speeds and start positions handed to the DUT
   localparam int Speed1  = 16;
   localparam int Speed2  = 3;
   localparam int Start1X = 128;
   localparam int Start1Y = 128;
   localparam int Start2X = 448;
   localparam int Start2Y = 448;

   logic                                     clk;
   logic                                     reset_n;
   logic                                     eof;
   logic                                     p1Up;
   logic                                     p1Down;
   logic                                     p1Left;
   logic                                     p1Right;
   logic                                     p2Up;
   logic                                     p2Down;
   logic                                     p2Left;
   logic                                     p2Right;
   logic signed [screenPkg::CoordWidth-1:0]  player1X;
   logic signed [screenPkg::CoordWidth-1:0]  player1Y;
   logic signed [screenPkg::CoordWidth-1:0]  player2X;
   logic signed [screenPkg::CoordWidth-1:0]  player2Y;
   gamePkg::SpriteId                         player1Sprite;
   gamePkg::SpriteId                         player2Sprite;
   logic [screenPkg::TileAddrWidth-1:0]      ramRaddr;
   logic [screenPkg::TileWidth-1:0]          ramRdata;

   // Testbench copy of the maze
   logic [screenPkg::TileWidth-1:0]          maze [0:NumTiles-1];

   integer                                   seed;
   int                                       errorCount;
   int                                       checkCount;
   int                                       moveCount;
   int                                       wallCount;
   int                                       offGridCount;
   int                                       bothCount;

   // Reference model state, index 1 and 2 per player
   int                                       mFixX [1:2];
   int                                       mFixY [1:2];
   int                                       mTgtX [1:2];
   int                                       mTgtY [1:2];
   int                                       mSpeed [1:2];
   int                                       mDir [1:2];
   int                                       mSprite [1:2];
   bit                                       mMoving [1:2];
   bit                                       mPhase [1:2];

   gameController #(
      .Speed1  (Speed1),
      .Speed2  (Speed2),
      .Start1X (Start1X),
      .Start1Y (Start1Y),
      .Start2X (Start2X),
      .Start2Y (Start2Y)
   ) dut (
      .clk           (clk),
      .reset_n       (reset_n),
      .eof           (eof),
      .p1Up          (p1Up),
      .p1Down        (p1Down),
      .p1Left        (p1Left),
      .p1Right       (p1Right),
      .p2Up          (p2Up),
      .p2Down        (p2Down),
      .p2Left        (p2Left),
      .p2Right       (p2Right),
      .player1X      (player1X),
      .player1Y      (player1Y),
      .player2X      (player2X),
      .player2Y      (player2Y),
      .player1Sprite (player1Sprite),
      .player2Sprite (player2Sprite),
      .ramRaddr      (ramRaddr),
      .ramRdata      (ramRdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #(ClockPeriod / 2) clk = ~clk;
   end

   // Maze RAM, data one cycle after the address
   always @(posedge clk)
   begin
      if (ramRaddr < NumTiles)
      begin
         ramRdata <= maze[ramRaddr];
      end
      else
      begin
         ramRdata <= '0;
      end
   end

   task automatic compareValue(input logic signed [31:0] actual,
                               input logic signed [31:0] expected, input string what);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("CHECK FAILED at time %0t: %s is %0d, expected %0d",
                  $time, what, actual, expected);
      end
   endtask

   // Walking image for a direction, 0 up, 1 down, 2 left, 3 right
   function automatic int walkSprite(input int dir, input bit phase);
      case (dir)
         0:       return phase ? int'(gamePkg::Up2) : int'(gamePkg::Up1);
         3:       return phase ? int'(gamePkg::Right2) : int'(gamePkg::Right1);
         2:       return phase ? int'(gamePkg::Left2) : int'(gamePkg::Left1);
         default: return int'(gamePkg::Face);
      endcase
   endfunction

   // Keys as {up, down, right, left}, none in about a quarter of frames
   task automatic pickKeys(output logic [3:0] keys);
      keys = 4'($random(seed));
      if (($random(seed) & 3) == 0)
      begin
         keys = 4'b0000;
      end
   endtask

   // One frame of the reference model for player p at an eof
   task automatic advanceModel(input int p, input logic [3:0] keys, output bit lookedUp,
                               output int addr);
      int  col;
      int  row;
      int  dCol;
      int  dRow;
      int  dir;
      int  axis;
      int  nextPos;
      int  target;
      bit  vertical;
      bit  negative;
      bit  arrive;
      lookedUp = 1'b0;
      addr     = 0;
      if (mMoving[p])
      begin
         mSprite[p] = walkSprite(mDir[p], mPhase[p]);
         mPhase[p]  = !mPhase[p];
         vertical   = (mDir[p] == 0) || (mDir[p] == 1);
         negative   = (mDir[p] == 0) || (mDir[p] == 2);
         axis       = vertical ? mFixY[p] : mFixX[p];
         target     = (vertical ? mTgtY[p] : mTgtX[p]) * FixScale;
         nextPos    = negative ? axis - mSpeed[p] * FixScale : axis + mSpeed[p] * FixScale;
         arrive     = negative ? (nextPos <= target) : (nextPos >= target);
         if (arrive)
         begin
            // Snap, fraction cleared
            mFixX[p]   = mTgtX[p] * FixScale;
            mFixY[p]   = mTgtY[p] * FixScale;
            mMoving[p] = 1'b0;
         end
         else if (vertical)
         begin
            mFixY[p] = nextPos;
         end
         else
         begin
            mFixX[p] = nextPos;
         end
      end
      else
      begin
         mSprite[p] = int'(gamePkg::Face);
         dCol = 0;
         dRow = 0;
         dir  = -1;
         if (keys[3])
         begin
            dir  = 0;
            dRow = -1;
         end
         else if (keys[2])
         begin
            dir  = 1;
            dRow = 1;
         end
         else if (keys[1])
         begin
            dir  = 3;
            dCol = 1;
         end
         else if (keys[0])
         begin
            dir  = 2;
            dCol = -1;
         end
         if (dir >= 0)
         begin
            col = mFixX[p] / (FixScale * screenPkg::TileSize) + dCol;
            row = mFixY[p] / (FixScale * screenPkg::TileSize) + dRow;
            if (col < 0 || col >= screenPkg::GridCols || row < 0 || row >= screenPkg::GridRows)
            begin
               offGridCount++;
            end
            else
            begin
               lookedUp = 1'b1;
               addr     = row * screenPkg::GridCols + col;
               if (maze[addr] != 0)
               begin
                  wallCount++;
               end
               else
               begin
                  moveCount++;
                  mMoving[p] = 1'b1;
                  mPhase[p]  = 1'b0;
                  mDir[p]    = dir;
                  mTgtX[p]   = col * screenPkg::TileSize;
                  mTgtY[p]   = row * screenPkg::TileSize;
               end
            end
         end
      end
   endtask

   // Visible pixel is the fixed-point value without its fraction
   task automatic checkOutputs();
      compareValue(player1X, mFixX[1] / FixScale, "player 1 X");
      compareValue(player1Y, mFixY[1] / FixScale, "player 1 Y");
      compareValue(player1Sprite, mSprite[1], "player 1 sprite");
      compareValue(player2X, mFixX[2] / FixScale, "player 2 X");
      compareValue(player2Y, mFixY[2] / FixScale, "player 2 Y");
      compareValue(player2Sprite, mSprite[2], "player 2 sprite");
   endtask

   // Watchdog sized from the frame count
   initial
   begin
      #(TimeoutTime);
      $display("Run timed out after %0t time units without finishing", $time);
      $display("Simulation failed");
      $finish;
   end

   initial
   begin
      logic [3:0] keys1;
      logic [3:0] keys2;
      bit         look1;
      bit         look2;
      int         addr1;
      int         addr2;
      int         firstAddr;
      int         secondAddr;
      bit         lastServed2;
      int         r;
      reset_n      = 1'b0;
      eof          = 1'b0;
      {p1Up, p1Down, p1Left, p1Right} = 4'b0000;
      {p2Up, p2Down, p2Left, p2Right} = 4'b0000;
      ramRdata     = '0;
      seed         = 31;
      errorCount   = 0;
      checkCount   = 0;
      moveCount    = 0;
      wallCount    = 0;
      offGridCount = 0;
      bothCount    = 0;
      // Round robin starts with player 1
      lastServed2  = 1'b1;

      // About one tile in four is a wall, wall values are nonzero
      for (int i = 0; i < NumTiles; i++)
      begin
         r = $random(seed);
         maze[i] = ((r & 3) == 0) ? 4'(((r >> 2) & 7) + 1) : 4'd0;
      end

      mFixX   = '{Start1X * FixScale, Start2X * FixScale};
      mFixY   = '{Start1Y * FixScale, Start2Y * FixScale};
      mSpeed  = '{Speed1, Speed2};
      mTgtX   = '{0, 0};
      mTgtY   = '{0, 0};
      mDir    = '{0, 0};
      mSprite = '{int'(gamePkg::Face), int'(gamePkg::Face)};
      mMoving = '{1'b0, 1'b0};
      mPhase  = '{1'b0, 1'b0};

      repeat (ResetCycles) @(posedge clk);
      #(DriveDelay);
      reset_n = 1'b1;

      // Start positions and Face before any eof
      repeat (2) @(posedge clk);
      #(DriveDelay);
      checkOutputs();

      for (int frame = 0; frame < NumFrames; frame++)
      begin
         @(posedge clk);
         #(DriveDelay);
         pickKeys(keys1);
         pickKeys(keys2);
         {p1Up, p1Down, p1Right, p1Left} = keys1;
         {p2Up, p2Down, p2Right, p2Left} = keys2;
         eof = 1'b1;
         advanceModel(1, keys1, look1, addr1);
         advanceModel(2, keys2, look2, addr2);
         // Expected order of RAM reads in this frame
         firstAddr  = look1 ? addr1 : addr2;
         secondAddr = addr2;
         if (look1 && look2)
         begin
            bothCount++;
            // The player not served last goes first, pointer ends where it was
            firstAddr  = lastServed2 ? addr1 : addr2;
            secondAddr = lastServed2 ? addr2 : addr1;
         end
         else if (look1 || look2)
         begin
            lastServed2 = look2;
         end
         @(posedge clk);
         #(DriveDelay);
         eof = 1'b0;
         // Query latched, first grant drives the RAM address
         @(posedge clk);
         #(DriveDelay);
         if (look1 || look2)
         begin
            compareValue(ramRaddr, firstAddr, "first RAM read address");
         end
         @(posedge clk);
         #(DriveDelay);
         if (look1 && look2)
         begin
            compareValue(ramRaddr, secondAddr, "second RAM read address");
         end
         repeat (CheckDelay - 3) @(posedge clk);
         #(DriveDelay);
         checkOutputs();
         repeat (FramePeriod - CheckDelay - 1) @(posedge clk);
      end

      $display("Checks %0d, errors %0d, moves %0d, walls %0d, off grid %0d, shared frames %0d",
               checkCount, errorCount, moveCount, wallCount, offGridCount, bothCount);
      if (errorCount == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- list.f
rtl/screenPkg.sv
rtl/gamePkg.sv
rtl/playerMover.sv
rtl/mazePort.sv
rtl/gameController.sv
tests/gameController_assertions.sv
tests/tb_gameController.sv
